/* verilog/decode_config.svh */
// Widths for the decode stage; the LUI shift assumes the data word is twice the immediate width
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Datapath word
`define DEC_DATA_W      32

// Register index, also used for the link register number
`define DEC_REG_ADDR_W  5

// Instruction fields
`define DEC_OP_W        6
`define DEC_FUNCT_W     6
`define DEC_SHAMT_W     5
`define DEC_IMM_W       16

// JAL writes its return address here
`define DEC_LINK_REG    31

`endif

/* verilog/mips_decode_pkg.sv */
// Shared decode types and encodings; only the opcodes and functs listed here are legal
`include "decode_config.svh"

package mips_decode_pkg;

    typedef struct packed {
        logic [`DEC_OP_W-1:0]       op;
        logic [`DEC_REG_ADDR_W-1:0] rs;
        logic [`DEC_REG_ADDR_W-1:0] rt;
        logic [`DEC_REG_ADDR_W-1:0] rd;     // Upper immediate bits in I-type
        logic [`DEC_SHAMT_W-1:0]    shamt;
        logic [`DEC_FUNCT_W-1:0]    funct;
    } instr_t;

    // Bit 0 is reg_dst, bit 14 is mem_to_reg
    typedef struct packed {
        logic       mem_to_reg;
        logic       bds_sel;                // Write PC+8 for JAL and JALR
        logic       reg_write;
        logic       jump_sel;               // Jump target from rs
        logic       jump;                   // Jump target from instr_index
        logic       mem_write;
        logic       mem_read;
        logic       equal;                  // BEQ when set, BNE when clear
        logic       branch;
        logic [2:0] alu_op;
        logic       alu_src;                // Second operand from immediate
        logic       jal_sel;                // Destination is the link register
        logic       reg_dst;                // Destination is rd
    } ctrl_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
        ALU_LUI, ALU_PASS
    } alu_func_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef struct packed {
        ctrl_t                      ctrl;
        alu_func_t                  alu_func;
        mem_size_t                  mem_size;
        logic                       mem_unsigned;
        logic [`DEC_REG_ADDR_W-1:0] rs;
        logic [`DEC_REG_ADDR_W-1:0] rt;
        logic [`DEC_REG_ADDR_W-1:0] dest;
        logic [`DEC_SHAMT_W-1:0]    shamt;
        logic [`DEC_DATA_W-1:0]     imm32;
        logic                       illegal;
    } decoded_t;

    // ALUOp codes between the two control units
    localparam logic [2:0] ALUOP_ADD   = 3'b000;  // Loads, stores, ADDI
    localparam logic [2:0] ALUOP_SUB   = 3'b001;  // Branch compare
    localparam logic [2:0] ALUOP_RTYPE = 3'b010;  // Look at funct
    localparam logic [2:0] ALUOP_XOR   = 3'b011;
    localparam logic [2:0] ALUOP_AND   = 3'b100;
    localparam logic [2:0] ALUOP_LUI   = 3'b101;
    localparam logic [2:0] ALUOP_OR    = 3'b110;
    localparam logic [2:0] ALUOP_SLT   = 3'b111;

    // Opcodes
    localparam logic [`DEC_OP_W-1:0] OP_SPECIAL = 6'b000000;
    localparam logic [`DEC_OP_W-1:0] OP_J       = 6'b000010;
    localparam logic [`DEC_OP_W-1:0] OP_JAL     = 6'b000011;
    localparam logic [`DEC_OP_W-1:0] OP_BEQ     = 6'b000100;
    localparam logic [`DEC_OP_W-1:0] OP_BNE     = 6'b000101;
    localparam logic [`DEC_OP_W-1:0] OP_ADDI    = 6'b001000;
    localparam logic [`DEC_OP_W-1:0] OP_SLTI    = 6'b001010;
    localparam logic [`DEC_OP_W-1:0] OP_ANDI    = 6'b001100;
    localparam logic [`DEC_OP_W-1:0] OP_ORI     = 6'b001101;
    localparam logic [`DEC_OP_W-1:0] OP_XORI    = 6'b001110;
    localparam logic [`DEC_OP_W-1:0] OP_LUI     = 6'b001111;
    localparam logic [`DEC_OP_W-1:0] OP_LB      = 6'b100000;
    localparam logic [`DEC_OP_W-1:0] OP_LH      = 6'b100001;
    localparam logic [`DEC_OP_W-1:0] OP_LW      = 6'b100011;
    localparam logic [`DEC_OP_W-1:0] OP_LBU     = 6'b100100;
    localparam logic [`DEC_OP_W-1:0] OP_LHU     = 6'b100101;
    localparam logic [`DEC_OP_W-1:0] OP_LWU     = 6'b100110;
    localparam logic [`DEC_OP_W-1:0] OP_SB      = 6'b101000;
    localparam logic [`DEC_OP_W-1:0] OP_SH      = 6'b101001;
    localparam logic [`DEC_OP_W-1:0] OP_SW      = 6'b101011;

    // Functs under OP_SPECIAL
    localparam logic [`DEC_FUNCT_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [`DEC_FUNCT_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [`DEC_FUNCT_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [`DEC_FUNCT_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [`DEC_FUNCT_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [`DEC_FUNCT_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [`DEC_FUNCT_W-1:0] FN_JR   = 6'b001000;
    localparam logic [`DEC_FUNCT_W-1:0] FN_JALR = 6'b001001;
    localparam logic [`DEC_FUNCT_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [`DEC_FUNCT_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [`DEC_FUNCT_W-1:0] FN_AND  = 6'b100100;
    localparam logic [`DEC_FUNCT_W-1:0] FN_OR   = 6'b100101;
    localparam logic [`DEC_FUNCT_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [`DEC_FUNCT_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [`DEC_FUNCT_W-1:0] FN_SLT  = 6'b101010;

endpackage

/* verilog/pipe_stage.sv */
// One-entry valid/ready register; ready is combinational from i_ready, so chained stages form one ready path
module pipe_stage
    #(
        parameter type T = logic
    )
    (
        input  logic i_clk,
        input  logic i_rst_n,
        // Upstream side
        input  logic i_valid,
        input  T     i_data,
        output logic o_ready,
        // Downstream side
        output logic o_valid,
        output T     o_data,
        input  logic i_ready
    );

    logic valid_q;
    T     data_q;

    // Room when empty or when the entry leaves this cycle
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (o_ready)
        begin
            valid_q <= i_valid;                 // Refill or drain
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid && o_ready)
        begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

/* verilog/main_control_unit.sv */
// Main control decode; R-type funct legality is left to the ALU control unit, except JR and JALR
`include "decode_config.svh"

module main_control_unit
    import mips_decode_pkg::*;
    (
        input  logic [`DEC_OP_W-1:0]    i_op,
        input  logic [`DEC_FUNCT_W-1:0] i_funct,
        output ctrl_t                   o_ctrl,
        output mem_size_t               o_mem_size,
        output logic                    o_mem_unsigned,
        output logic                    o_illegal
    );

    // Control words per instruction class
    localparam ctrl_t CW_RTYPE = '{reg_dst: 1'b1, reg_write: 1'b1, alu_op: ALUOP_RTYPE,
                                   default: '0};
    localparam ctrl_t CW_LOAD  = '{alu_src: 1'b1, alu_op: ALUOP_ADD, mem_read: 1'b1,
                                   reg_write: 1'b1, mem_to_reg: 1'b1, default: '0};
    localparam ctrl_t CW_STORE = '{alu_src: 1'b1, alu_op: ALUOP_ADD, mem_write: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_ADDI  = '{alu_src: 1'b1, alu_op: ALUOP_ADD, reg_write: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_ANDI  = '{alu_src: 1'b1, alu_op: ALUOP_AND, reg_write: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_ORI   = '{alu_src: 1'b1, alu_op: ALUOP_OR, reg_write: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_XORI  = '{alu_src: 1'b1, alu_op: ALUOP_XOR, reg_write: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_LUI   = '{alu_src: 1'b1, alu_op: ALUOP_LUI, reg_write: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_SLTI  = '{alu_src: 1'b1, alu_op: ALUOP_SLT, reg_write: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_BEQ   = '{alu_op: ALUOP_SUB, branch: 1'b1, equal: 1'b1,
                                   default: '0};
    localparam ctrl_t CW_BNE   = '{alu_op: ALUOP_SUB, branch: 1'b1, default: '0};
    localparam ctrl_t CW_J     = '{jump: 1'b1, default: '0};
    localparam ctrl_t CW_JAL   = '{jal_sel: 1'b1, jump: 1'b1, reg_write: 1'b1,
                                   bds_sel: 1'b1, default: '0};
    localparam ctrl_t CW_JR    = '{alu_op: ALUOP_RTYPE, jump_sel: 1'b1, default: '0};
    localparam ctrl_t CW_JALR  = '{reg_dst: 1'b1, alu_op: ALUOP_RTYPE, jump_sel: 1'b1,
                                   reg_write: 1'b1, bds_sel: 1'b1, default: '0};

    always_comb
    begin
        o_ctrl         = '0;
        o_mem_size     = MEM_WORD;
        o_mem_unsigned = 1'b0;
        o_illegal      = 1'b0;
        case (i_op)
            OP_SPECIAL:
            begin
                case (i_funct)
                    FN_JR:   o_ctrl = CW_JR;
                    FN_JALR: o_ctrl = CW_JALR;
                    default: o_ctrl = CW_RTYPE;     // ALU funct checked downstream
                endcase
            end
            OP_LB, OP_LBU:
            begin
                o_ctrl         = CW_LOAD;
                o_mem_size     = MEM_BYTE;
                o_mem_unsigned = (i_op == OP_LBU);
            end
            OP_LH, OP_LHU:
            begin
                o_ctrl         = CW_LOAD;
                o_mem_size     = MEM_HALF;
                o_mem_unsigned = (i_op == OP_LHU);
            end
            OP_LW, OP_LWU:
            begin
                o_ctrl         = CW_LOAD;
                o_mem_unsigned = (i_op == OP_LWU);
            end
            OP_SB:
            begin
                o_ctrl     = CW_STORE;
                o_mem_size = MEM_BYTE;
            end
            OP_SH:
            begin
                o_ctrl     = CW_STORE;
                o_mem_size = MEM_HALF;
            end
            OP_SW:   o_ctrl = CW_STORE;
            OP_ADDI: o_ctrl = CW_ADDI;
            OP_ANDI: o_ctrl = CW_ANDI;
            OP_ORI:  o_ctrl = CW_ORI;
            OP_XORI: o_ctrl = CW_XORI;
            OP_LUI:  o_ctrl = CW_LUI;
            OP_SLTI: o_ctrl = CW_SLTI;
            OP_BEQ:  o_ctrl = CW_BEQ;
            OP_BNE:  o_ctrl = CW_BNE;
            OP_J:    o_ctrl = CW_J;
            OP_JAL:  o_ctrl = CW_JAL;
            default: o_illegal = 1'b1;              // Control lines stay zero
        endcase
    end

endmodule

/* verilog/alu_control_unit.sv */
// ALU function select; funct is only checked when ALUOp is the R-type code
`include "decode_config.svh"

module alu_control_unit
    import mips_decode_pkg::*;
    (
        input  logic [2:0]              i_alu_op,
        input  logic [`DEC_FUNCT_W-1:0] i_funct,
        output alu_func_t               o_alu_func,
        output logic                    o_illegal
    );

    always_comb
    begin
        o_alu_func = ALU_ADD;
        o_illegal  = 1'b0;
        case (i_alu_op)
            ALUOP_RTYPE:
            begin
                case (i_funct)
                    FN_ADDU: o_alu_func = ALU_ADD;
                    FN_SUBU: o_alu_func = ALU_SUB;
                    FN_AND:  o_alu_func = ALU_AND;
                    FN_OR:   o_alu_func = ALU_OR;
                    FN_XOR:  o_alu_func = ALU_XOR;
                    FN_NOR:  o_alu_func = ALU_NOR;
                    FN_SLT:  o_alu_func = ALU_SLT;
                    FN_SLL:  o_alu_func = ALU_SLL;          // Also the all-zero NOP
                    FN_SRL:  o_alu_func = ALU_SRL;
                    FN_SRA:  o_alu_func = ALU_SRA;
                    FN_SLLV: o_alu_func = ALU_SLLV;
                    FN_SRLV: o_alu_func = ALU_SRLV;
                    FN_SRAV: o_alu_func = ALU_SRAV;
                    FN_JR, FN_JALR:
                    begin
                        o_alu_func = ALU_PASS;              // Forward rs as jump target
                    end
                    default: o_illegal = 1'b1;
                endcase
            end
            ALUOP_SUB: o_alu_func = ALU_SUB;
            ALUOP_AND: o_alu_func = ALU_AND;
            ALUOP_OR:  o_alu_func = ALU_OR;
            ALUOP_XOR: o_alu_func = ALU_XOR;
            ALUOP_SLT: o_alu_func = ALU_SLT;
            ALUOP_LUI: o_alu_func = ALU_LUI;
            default:   o_alu_func = ALU_ADD;            // ALUOP_ADD
        endcase
    end

endmodule

/* verilog/instr_decoder.sv */
// Combinational decode of one word; any illegal word leaves all control lines at zero
`include "decode_config.svh"

module instr_decoder
    import mips_decode_pkg::*;
    (
        input  instr_t   i_instr,
        output decoded_t o_dec
    );

    localparam int EXT_W = `DEC_DATA_W - `DEC_IMM_W;

    ctrl_t                  ctrl;
    mem_size_t              mem_size;
    logic                   mem_unsigned;
    logic                   main_illegal;
    alu_func_t              alu_func;
    logic                   alu_illegal;
    logic                   illegal;
    ctrl_t                  ctrl_final;
    logic [`DEC_IMM_W-1:0]  imm16;
    logic [`DEC_DATA_W-1:0] imm32;

    main_control_unit main_ctrl_i (
        .i_op           (i_instr.op),
        .i_funct        (i_instr.funct),
        .o_ctrl         (ctrl),
        .o_mem_size     (mem_size),
        .o_mem_unsigned (mem_unsigned),
        .o_illegal      (main_illegal)
    );

    alu_control_unit alu_ctrl_i (
        .i_alu_op   (ctrl.alu_op),
        .i_funct    (i_instr.funct),
        .o_alu_func (alu_func),
        .o_illegal  (alu_illegal)
    );

    assign illegal    = main_illegal || alu_illegal;
    assign ctrl_final = illegal ? '0 : ctrl;        // Squash bad R-type functs too

    assign imm16 = {i_instr.rd, i_instr.shamt, i_instr.funct};

    always_comb
    begin
        case (i_instr.op)
            OP_ANDI, OP_ORI, OP_XORI: imm32 = {{EXT_W{1'b0}}, imm16};
            OP_LUI:                   imm32 = {imm16, {EXT_W{1'b0}}};
            default:                  imm32 = {{EXT_W{imm16[`DEC_IMM_W-1]}}, imm16};
        endcase
    end

    always_comb
    begin
        o_dec.ctrl         = ctrl_final;
        o_dec.alu_func     = alu_func;
        o_dec.mem_size     = mem_size;
        o_dec.mem_unsigned = mem_unsigned;
        o_dec.rs           = i_instr.rs;
        o_dec.rt           = i_instr.rt;
        o_dec.shamt        = i_instr.shamt;
        o_dec.imm32        = imm32;
        o_dec.illegal      = illegal;
        // JALSel wins over RegDst
        if (ctrl_final.jal_sel)
            o_dec.dest = `DEC_REG_ADDR_W'(`DEC_LINK_REG);
        else if (ctrl_final.reg_dst)
            o_dec.dest = i_instr.rd;
        else
            o_dec.dest = i_instr.rt;
    end

endmodule

/* verilog/decode_stage_top.sv */
// Decode stage top; two registered stages give two cycles of latency with no stalls
module decode_stage_top
    import mips_decode_pkg::*;
    (
        input  logic     i_clk,
        input  logic     i_rst_n,
        // Instruction input
        input  logic     i_instr_valid,
        input  instr_t   i_instr,
        output logic     o_instr_ready,
        // Decoded output
        output logic     o_dec_valid,
        output decoded_t o_dec,
        input  logic     i_dec_ready
    );

    logic     instr_q_valid;
    instr_t   instr_q;
    logic     dec_stage_ready;
    decoded_t dec_comb;

    pipe_stage #(.T(instr_t)) in_stage_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_instr_valid),
        .i_data  (i_instr),
        .o_ready (o_instr_ready),
        .o_valid (instr_q_valid),
        .o_data  (instr_q),
        .i_ready (dec_stage_ready)
    );

    instr_decoder decoder_i (
        .i_instr (instr_q),
        .o_dec   (dec_comb)
    );

    pipe_stage #(.T(decoded_t)) out_stage_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (instr_q_valid),
        .i_data  (dec_comb),
        .o_ready (dec_stage_ready),
        .o_valid (o_dec_valid),
        .o_data  (o_dec),
        .i_ready (i_dec_ready)
    );

endmodule

/* bench/decode_props.sv */
// Properties on the decode output handshake only; the reset property expects a synchronous reset
module decode_props
    import mips_decode_pkg::*;
    (
        input logic     i_clk,
        input logic     i_rst_n,
        input logic     i_dec_valid,
        input decoded_t i_dec,
        input logic     i_dec_ready
    );

    // Output stage empty after any reset cycle
    a_reset_clears_valid: assert property (@(posedge i_clk) !i_rst_n |=> !i_dec_valid)
        else $error("o_dec_valid high after reset");

    a_out_stall_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_dec_valid && !i_dec_ready |=> i_dec_valid && $stable(i_dec))
        else $error("Decoded output changed while stalled");

    // Illegal words carry no control lines
    a_illegal_ctrl_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_dec_valid && i_dec.illegal |-> i_dec.ctrl == '0)
        else $error("Illegal word with control lines set");

endmodule

bind decode_stage_top decode_props props_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_dec_valid (o_dec_valid),
    .i_dec       (o_dec),
    .i_dec_ready (i_dec_ready)
);

/* bench/tb_decode_stage.sv */
// Decode stage testbench; run from the project root so the test data path resolves
module tb_decode_stage
    import mips_decode_pkg::*;
    ();

    localparam int NUM_VEC        = 38;
    localparam int WORDS_PER_VEC  = 4;
    localparam int GAP_LIMIT      = 32;
    localparam int ACCEPT_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT  = 400;
    localparam int QUIET_CYCLES   = 16;

    logic     clk;
    logic     rst_n;
    logic     i_instr_valid;
    instr_t   i_instr;
    logic     o_instr_ready;
    logic     o_dec_valid;
    decoded_t o_dec;
    logic     i_dec_ready;

    logic [31:0] vec_mem [0:NUM_VEC*WORDS_PER_VEC-1];
    logic [15:0] gap_lfsr;
    logic [15:0] stall_lfsr;
    int          in_count;
    int          out_count;

    decode_stage_top dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .o_dec_valid   (o_dec_valid),
        .o_dec         (o_dec),
        .i_dec_ready   (i_dec_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic decoded_t expected_for(input int idx);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        decoded_t    e;
        w0             = vec_mem[idx*WORDS_PER_VEC];
        w1             = vec_mem[idx*WORDS_PER_VEC+1];
        w2             = vec_mem[idx*WORDS_PER_VEC+2];
        w3             = vec_mem[idx*WORDS_PER_VEC+3];
        e.ctrl         = ctrl_t'(w1[30:16]);
        e.alu_func     = alu_func_t'(w1[15:12]);
        e.mem_size     = mem_size_t'(w1[9:8]);
        e.mem_unsigned = w1[4];
        e.rs           = w0[25:21];             // MIPS field positions
        e.rt           = w0[20:16];
        e.dest         = w2[4:0];
        e.shamt        = w0[10:6];
        e.imm32        = w3;
        e.illegal      = w1[0];
        return e;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act)
        begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run("A DUT output differs from its expected value");
        end
    endtask

    task automatic wait_accept;
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!o_instr_ready)
        begin
            cycles++;
            if (cycles > ACCEPT_TIMEOUT)
                abort_run("The DUT never accepted an instruction word");
            @(posedge clk);
        end
    endtask

    // Output back-pressure with ready about three cycles in four
    always @(negedge clk)
    begin
        logic b0;
        logic b1;
        stall_lfsr  = lfsr_next(stall_lfsr);
        b0          = stall_lfsr[0];
        stall_lfsr  = lfsr_next(stall_lfsr);
        b1          = stall_lfsr[0];
        i_dec_ready = b0 | b1;
    end

    // In-order scoreboard on output transfers
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (o_dec_valid && in_count == 0)
                abort_run("Output valid before any instruction was accepted");
            if (o_dec_valid && i_dec_ready)
            begin
                if (out_count >= NUM_VEC)
                    abort_run("More outputs than instruction words sent");
                check_value($sformatf("vec%0d", out_count),
                            128'(expected_for(out_count)), 128'(o_dec));
                out_count++;
            end
            if (i_instr_valid && o_instr_ready)
                in_count++;
        end
    end

    initial
    begin
        int gap;
        int waited;
        rst_n         = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_dec_ready   = 1'b1;
        gap_lfsr      = 16'd55;
        stall_lfsr    = 16'd55;
        in_count      = 0;
        out_count     = 0;
        $readmemh("bench/decode_testdata.hex", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*WORDS_PER_VEC-1]))
            abort_run("The test data file is missing or too short");

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("reset_dec_valid", 128'(1'b0), 128'(o_dec_valid));
        check_value("reset_instr_ready", 128'(1'b1), 128'(o_instr_ready));

        for (int idx = 0; idx < NUM_VEC; idx++)
        begin
            gap = 0;
            @(negedge clk);
            gap_lfsr = lfsr_next(gap_lfsr);
            while (gap_lfsr[0])                 // Random idle cycle
            begin
                i_instr_valid = 1'b0;
                gap++;
                if (gap > GAP_LIMIT)
                    abort_run("The input gap generator got stuck");
                @(negedge clk);
                gap_lfsr = lfsr_next(gap_lfsr);
            end
            i_instr       = instr_t'(vec_mem[idx*WORDS_PER_VEC]);
            i_instr_valid = 1'b1;
            wait_accept();
        end
        @(negedge clk);
        i_instr_valid = 1'b0;

        waited = 0;
        while (out_count < NUM_VEC)
        begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT)
                abort_run("Not all decoded words came out of the DUT");
        end

        // Any extra output here is a duplicate
        repeat (QUIET_CYCLES) @(negedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* bench/decode_testdata.hex */
// Per line: instruction word, then {ctrl[15:0], alu_func, mem_size, mem_unsigned, illegal}
// as one nibble each after ctrl, then expected dest, then expected imm32
00221821 10110200 00000003 00001821
00221823 10111200 00000003 00001823
00221824 10112200 00000003 00001824
00221825 10113200 00000003 00001825
00221826 10114200 00000003 00001826
00221827 10115200 00000003 00001827
0022182a 10116200 00000003 0000182a
00221940 10117200 00000003 00001940
00221942 10118200 00000003 00001942
00221943 10119200 00000003 00001943
00221804 1011a200 00000003 00001804
00221806 1011b200 00000003 00001806
00221807 1011c200 00000003 00001807
00200008 0810e200 00000000 00000008
0020f809 3811e200 0000001f fffff809
0022183f 00000201 00000002 0000183f
8022fffc 51040000 00000002 fffffffc
84220010 51040100 00000002 00000010
8c228004 51040200 00000002 ffff8004
90220001 51040010 00000002 00000001
94220002 51040110 00000002 00000002
98220003 51040210 00000002 00000003
a0220004 02040000 00000002 00000004
a4220006 02040100 00000002 00000006
ac22fff8 02040200 00000002 fffffff8
2022ffff 10040200 00000002 ffffffff
3022f0f0 10242200 00000002 0000f0f0
34228001 10343200 00000002 00008001
3822ffff 101c4200 00000002 0000ffff
3c221234 102cd200 00000002 12340000
2822ff00 103c6200 00000002 ffffff00
1022fffe 00c81200 00000002 fffffffe
14220010 00481200 00000002 00000010
08000040 04000200 00000000 00000040
0c100123 34020200 0000001f 00000123
fc221234 00000201 00000002 00001234
04228000 00000201 00000002 ffff8000
00000000 10117200 00000000 00000000

/* vlog.f */
+incdir+verilog
verilog/mips_decode_pkg.sv
verilog/pipe_stage.sv
verilog/main_control_unit.sv
verilog/alu_control_unit.sv
verilog/instr_decoder.sv
verilog/decode_stage_top.sv
bench/decode_props.sv
bench/tb_decode_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_decode_stage -f vlog.f -o sim_decode
output=$(./obj_dir/sim_decode 2>&1) || true
echo "$output"
echo "$output" | grep -q "SIMULATION PASSED"
